/* hdl/ddcpu_pkg.sv */
package ddcpu_pkg;

   parameter int ADDR_WIDTH   = 32;
   parameter int DATA_WIDTH   = 32;
   parameter int OPCODE_WIDTH = 4;
   parameter int TAG_WIDTH    = 12;
   parameter int VALUE_WIDTH  = 16;

   // codes not listed here pass the value through
   typedef enum logic [OPCODE_WIDTH-1:0] {
      OP_END  = 4'd0,
      OP_JUMP = 4'd1,
      OP_INC  = 4'd2,
      OP_NEG  = 4'd3,
      OP_XOR  = 4'd4,
      OP_SQR  = 4'd5
   } opcode_e;

   parameter logic [VALUE_WIDTH-1:0] XOR_KEY = 16'h5A5A;

   typedef struct packed {
      opcode_e                opcode;
      logic [TAG_WIDTH-1:0]   tag;
      logic [VALUE_WIDTH-1:0] value;
   } op_view_t;

   // word index, byte address is index * 4
   typedef struct packed {
      opcode_e                              opcode;
      logic [DATA_WIDTH-OPCODE_WIDTH-1:0]   target;
   } jump_view_t;

   typedef union packed {
      op_view_t   op;
      jump_view_t jump;
   } packet_t;

   typedef packet_t op_packet_t;

   typedef struct packed {
      logic [TAG_WIDTH-1:0]   tag;
      logic [VALUE_WIDTH-1:0] value;
   } result_t;

endpackage

/* hdl/ddcpu_top.sv */
`timescale 1ns/1ns

module ddcpu_top #(
   parameter int WORKER_NUM  = 3,
   parameter int QUEUE_DEPTH = 8
) (
   input  logic                                CLK,
   input  logic                                RST,
   input  logic                                i_start,
   input  logic [ddcpu_pkg::ADDR_WIDTH-1:0]    i_pcaddr,
   output logic                                o_stop,
   output logic [ddcpu_pkg::ADDR_WIDTH-1:0]    o_araddr,
   output logic                                o_arvalid,
   input  logic                                i_arready,
   input  logic [ddcpu_pkg::DATA_WIDTH-1:0]    i_rdata,
   input  logic                                i_rvalid,
   output logic                                o_rready,
   output logic                                o_res_valid,
   output logic [ddcpu_pkg::TAG_WIDTH-1:0]     o_res_tag,
   output logic [ddcpu_pkg::VALUE_WIDTH-1:0]   o_res_value,
   input  logic                                i_res_ready
);

   ddcpu_pkg::op_packet_t ld_pkt;
   logic                  ld_valid;
   logic                  ld_ready;
   logic                  issue;
   logic                  fetch_done;

   ddcpu_pkg::op_packet_t q_pkt;
   logic                  q_valid;
   logic                  q_ready;

   logic [WORKER_NUM-1:0] wk_valid;
   logic [WORKER_NUM-1:0] wk_ready;

   // per-worker results, flattened
   ddcpu_pkg::result_t [WORKER_NUM-1:0] wk_res;
   logic [WORKER_NUM-1:0]               wk_res_valid;
   logic [WORKER_NUM-1:0]               wk_res_ready;

   packet_loader u_loader (
      .CLK          (CLK),
      .RST          (RST),
      .i_start      (i_start),
      .i_stop       (o_stop),
      .i_pcaddr     (i_pcaddr),
      .o_araddr     (o_araddr),
      .o_arvalid    (o_arvalid),
      .i_arready    (i_arready),
      .i_rdata      (i_rdata),
      .i_rvalid     (i_rvalid),
      .o_rready     (o_rready),
      .o_pkt        (ld_pkt),
      .o_pkt_valid  (ld_valid),
      .i_pkt_ready  (ld_ready),
      .o_issue      (issue),
      .o_fetch_done (fetch_done)
   );

   packet_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
      .CLK          (CLK),
      .RST          (RST),
      .i_pkt        (ld_pkt),
      .i_push_valid (ld_valid),
      .o_push_ready (ld_ready),
      .o_pkt        (q_pkt),
      .o_pop_valid  (q_valid),
      .i_pop_ready  (q_ready)
   );

   // packet data goes straight to every worker, only valid is steered
   worker_fork #(.WORKER_NUM(WORKER_NUM)) u_fork (
      .CLK         (CLK),
      .RST         (RST),
      .i_pkt_valid (q_valid),
      .o_pkt_ready (q_ready),
      .o_wk_valid  (wk_valid),
      .i_wk_ready  (wk_ready)
   );

   for (genvar w = 0; w < WORKER_NUM; w++) begin : g_worker
      worker u_worker (
         .CLK         (CLK),
         .RST         (RST),
         .i_pkt       (q_pkt),
         .i_pkt_valid (wk_valid[w]),
         .o_pkt_ready (wk_ready[w]),
         .o_res       (wk_res[w]),
         .o_res_valid (wk_res_valid[w]),
         .i_res_ready (wk_res_ready[w])
      );
   end

   dispatcher #(.WORKER_NUM(WORKER_NUM)) u_dispatcher (
      .CLK          (CLK),
      .RST          (RST),
      .i_start      (i_start),
      .i_wk_res     (wk_res),
      .i_wk_valid   (wk_res_valid),
      .o_wk_ready   (wk_res_ready),
      .i_issue      (issue),
      .i_fetch_done (fetch_done),
      .o_stop       (o_stop),
      .o_res_valid  (o_res_valid),
      .o_res_tag    (o_res_tag),
      .o_res_value  (o_res_value),
      .i_res_ready  (i_res_ready)
   );

endmodule

/* hdl/dispatcher.sv */
`timescale 1ns/1ns

module dispatcher #(
   parameter int WORKER_NUM = 3
) (
   input  logic                                CLK,
   input  logic                                RST,
   input  logic                                i_start,
   input  ddcpu_pkg::result_t [WORKER_NUM-1:0] i_wk_res,
   input  logic [WORKER_NUM-1:0]               i_wk_valid,
   output logic [WORKER_NUM-1:0]               o_wk_ready,
   input  logic                                i_issue,
   input  logic                                i_fetch_done,
   output logic                                o_stop,
   output logic                                o_res_valid,
   output logic [ddcpu_pkg::TAG_WIDTH-1:0]     o_res_tag,
   output logic [ddcpu_pkg::VALUE_WIDTH-1:0]   o_res_value,
   input  logic                                i_res_ready
);

   localparam int IDX_W = (WORKER_NUM > 1) ? $clog2(WORKER_NUM) : 1;
   localparam int CNT_W = 16;

   logic [IDX_W-1:0]   last;
   logic [IDX_W-1:0]   sel;
   logic               found;
   logic               take;
   logic               out_xfer;
   logic               exec_end;
   logic [CNT_W-1:0]   outstanding;
   ddcpu_pkg::result_t slot;
   int unsigned        cand;

   always_comb begin
      found = 1'b0;
      sel   = last;
      cand  = 0;
      for (int k = 0; k < WORKER_NUM; k++) begin
         cand = last + 1 + k;
         if (cand >= WORKER_NUM) cand = cand - WORKER_NUM;
         if (!found && i_wk_valid[cand]) begin
            found = 1'b1;
            sel   = IDX_W'(cand);
         end
      end
   end

   // slot refills in the same cycle it drains
   assign take     = found && (!o_res_valid || i_res_ready);
   assign out_xfer = o_res_valid && i_res_ready;
   assign exec_end = i_fetch_done && (outstanding == '0) && !o_stop;

   always_comb begin
      o_wk_ready = '0;
      if (take) o_wk_ready[sel] = 1'b1;
   end

   assign o_res_tag   = slot.tag;
   assign o_res_value = slot.value;

   always_ff @(posedge CLK) begin
      if (RST) begin
         last        <= IDX_W'(WORKER_NUM - 1);
         o_res_valid <= 1'b0;
         outstanding <= '0;
         o_stop      <= 1'b1;
      end else begin
         if (take) begin
            o_res_valid <= 1'b1;
            last        <= sel;
         end else if (out_xfer) begin
            o_res_valid <= 1'b0;
         end
         if (i_issue && !out_xfer) outstanding <= outstanding + 1'b1;
         else if (out_xfer && !i_issue) outstanding <= outstanding - 1'b1;
         if (exec_end) o_stop <= 1'b1;
         else if (i_start && o_stop) o_stop <= 1'b0;
      end
   end

   always_ff @(posedge CLK) begin
      if (take) slot <= i_wk_res[sel];
   end

   // every result leaving must have been issued by the loader
   a_outstanding_nonneg: assert property (@(posedge CLK) disable iff (RST)
      (out_xfer && !i_issue) |-> (outstanding != '0))
      else $error("result sent with no packet outstanding");

endmodule

/* hdl/packet_loader.sv */
`timescale 1ns/1ns

module packet_loader (
   input  logic                              CLK,
   input  logic                              RST,
   input  logic                              i_start,
   input  logic                              i_stop,
   input  logic [ddcpu_pkg::ADDR_WIDTH-1:0]  i_pcaddr,
   output logic [ddcpu_pkg::ADDR_WIDTH-1:0]  o_araddr,
   output logic                              o_arvalid,
   input  logic                              i_arready,
   input  logic [ddcpu_pkg::DATA_WIDTH-1:0]  i_rdata,
   input  logic                              i_rvalid,
   output logic                              o_rready,
   output ddcpu_pkg::op_packet_t             o_pkt,
   output logic                              o_pkt_valid,
   input  logic                              i_pkt_ready,
   output logic                              o_issue,
   output logic                              o_fetch_done
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_ADDR = 2'd1;
   localparam logic [1:0] ST_DATA = 2'd2;
   localparam logic [1:0] ST_PUSH = 2'd3;

   logic [1:0]                       state;
   ddcpu_pkg::packet_t               rd_word;
   logic [ddcpu_pkg::ADDR_WIDTH-1:0] jump_addr;
   logic                             rd_xfer;

   assign rd_word   = i_rdata;
   assign jump_addr = ddcpu_pkg::ADDR_WIDTH'({rd_word.jump.target, 2'b00});
   assign rd_xfer   = (state == ST_DATA) && i_rvalid;

   assign o_arvalid   = (state == ST_ADDR);
   assign o_rready    = (state == ST_DATA);
   assign o_pkt_valid = (state == ST_PUSH);
   assign o_issue     = o_pkt_valid && i_pkt_ready;

   always_ff @(posedge CLK) begin
      if (RST) begin
         state        <= ST_IDLE;
         o_fetch_done <= 1'b0;
      end else begin
         // new run clears the END marker
         if (i_start && i_stop) begin
            o_fetch_done <= 1'b0;
         end
         case (state)
            ST_IDLE: if (!i_stop && !o_fetch_done) state <= ST_ADDR;
            ST_ADDR: if (i_arready) state <= ST_DATA;
            ST_DATA: begin
               if (i_rvalid) begin
                  case (rd_word.op.opcode)
                     ddcpu_pkg::OP_END: begin
                        state        <= ST_IDLE;
                        o_fetch_done <= 1'b1;
                     end
                     ddcpu_pkg::OP_JUMP: state <= ST_ADDR;
                     default:            state <= ST_PUSH;
                  endcase
               end
            end
            default: if (i_pkt_ready) state <= ST_ADDR;
         endcase
      end
   end

   // fetch address and held packet
   always_ff @(posedge CLK) begin
      if (state == ST_IDLE) begin
         o_araddr <= i_pcaddr;
      end else if (rd_xfer && rd_word.op.opcode == ddcpu_pkg::OP_JUMP) begin
         o_araddr <= jump_addr;
      end else if (o_issue) begin
         o_araddr <= o_araddr + ddcpu_pkg::ADDR_WIDTH'(4);
      end
      if (rd_xfer) begin
         o_pkt <= rd_word;
      end
   end

   a_no_read_in_push: assert property (@(posedge CLK) disable iff (RST)
      (state == ST_PUSH) |-> $stable(o_araddr))
      else $error("read address moved while a packet waits for the queue");

endmodule

/* hdl/packet_queue.sv */
`timescale 1ns/1ns

module packet_queue #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic                  CLK,
   input  logic                  RST,
   input  ddcpu_pkg::op_packet_t i_pkt,
   input  logic                  i_push_valid,
   output logic                  o_push_ready,
   output ddcpu_pkg::op_packet_t o_pkt,
   output logic                  o_pop_valid,
   input  logic                  i_pop_ready
);

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

   ddcpu_pkg::op_packet_t mem [QUEUE_DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [PTR_W:0]        count;
   logic                  push;
   logic                  pop;

   assign o_push_ready = (count != (PTR_W + 1)'(QUEUE_DEPTH));
   assign o_pop_valid  = (count != '0);
   assign o_pkt        = mem[rd_ptr];
   assign push         = i_push_valid && o_push_ready;
   assign pop          = o_pop_valid && i_pop_ready;

   always_ff @(posedge CLK) begin
      if (RST) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // pointers wrap, depth is a power of two
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop) count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (push) mem[wr_ptr] <= i_pkt;
   end

   a_no_push_when_full: assert property (@(posedge CLK) disable iff (RST)
      count <= (PTR_W + 1)'(QUEUE_DEPTH))
      else $error("packet pushed into a full queue");

endmodule

/* hdl/worker.sv */
`timescale 1ns/1ns

module worker (
   input  logic                  CLK,
   input  logic                  RST,
   input  ddcpu_pkg::op_packet_t i_pkt,
   input  logic                  i_pkt_valid,
   output logic                  o_pkt_ready,
   output ddcpu_pkg::result_t    o_res,
   output logic                  o_res_valid,
   input  logic                  i_res_ready
);

   localparam int STEP_W = $clog2(ddcpu_pkg::VALUE_WIDTH);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_MUL  = 2'd1;
   localparam logic [1:0] ST_DONE = 2'd2;

   logic [1:0]                        state;
   logic [STEP_W-1:0]                 step;
   logic [ddcpu_pkg::VALUE_WIDTH-1:0] mcand;
   logic [ddcpu_pkg::VALUE_WIDTH-1:0] mplier;
   logic                              take;

   assign o_pkt_ready = (state == ST_IDLE);
   assign o_res_valid = (state == ST_DONE);
   assign take        = i_pkt_valid && o_pkt_ready;

   always_ff @(posedge CLK) begin
      if (RST) begin
         state <= ST_IDLE;
         step  <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (take) begin
                  step  <= '0;
                  state <= (i_pkt.op.opcode == ddcpu_pkg::OP_SQR) ? ST_MUL : ST_DONE;
               end
            end
            ST_MUL: begin
               step <= step + 1'b1;
               if (step == STEP_W'(ddcpu_pkg::VALUE_WIDTH - 1)) state <= ST_DONE;
            end
            default: if (i_res_ready) state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (take) begin
         o_res.tag <= i_pkt.op.tag;
         mcand     <= i_pkt.op.value;
         mplier    <= i_pkt.op.value;
         case (i_pkt.op.opcode)
            ddcpu_pkg::OP_INC: o_res.value <= i_pkt.op.value + 1'b1;
            ddcpu_pkg::OP_NEG: o_res.value <= -i_pkt.op.value;
            ddcpu_pkg::OP_XOR: o_res.value <= i_pkt.op.value ^ ddcpu_pkg::XOR_KEY;
            ddcpu_pkg::OP_SQR: o_res.value <= '0;
            default:           o_res.value <= i_pkt.op.value;
         endcase
      end else if (state == ST_MUL) begin
         // one shift-add step per cycle, low half only
         o_res.value <= o_res.value + (mplier[0] ? mcand : '0);
         mcand       <= mcand << 1;
         mplier      <= mplier >> 1;
      end
   end

   a_no_take_while_pending: assert property (@(posedge CLK) disable iff (RST)
      (o_res_valid && !i_res_ready) |=> (o_res_valid && $stable(o_res)))
      else $error("worker accepted a packet with a result pending");

endmodule

/* hdl/worker_fork.sv */
`timescale 1ns/1ns

module worker_fork #(
   parameter int WORKER_NUM = 3
) (
   input  logic                  CLK,
   input  logic                  RST,
   input  logic                  i_pkt_valid,
   output logic                  o_pkt_ready,
   output logic [WORKER_NUM-1:0] o_wk_valid,
   input  logic [WORKER_NUM-1:0] i_wk_ready
);

   localparam int IDX_W = (WORKER_NUM > 1) ? $clog2(WORKER_NUM) : 1;

   logic [IDX_W-1:0] last;
   logic [IDX_W-1:0] sel;
   logic             found;
   int unsigned      cand;

   // first idle worker after the last one served
   always_comb begin
      found = 1'b0;
      sel   = last;
      cand  = 0;
      for (int k = 0; k < WORKER_NUM; k++) begin
         cand = last + 1 + k;
         if (cand >= WORKER_NUM) cand = cand - WORKER_NUM;
         if (!found && i_wk_ready[cand]) begin
            found = 1'b1;
            sel   = IDX_W'(cand);
         end
      end
   end

   always_comb begin
      o_wk_valid = '0;
      if (i_pkt_valid && found) o_wk_valid[sel] = 1'b1;
   end

   assign o_pkt_ready = found;

   always_ff @(posedge CLK) begin
      if (RST) begin
         last <= IDX_W'(WORKER_NUM - 1);
      end else if (i_pkt_valid && found) begin
         last <= sel;
      end
   end

endmodule

/* list.f */
hdl/ddcpu_pkg.sv
hdl/packet_loader.sv
hdl/packet_queue.sv
hdl/worker_fork.sv
hdl/worker.sv
hdl/dispatcher.sv
hdl/ddcpu_top.sv
test/ddcpu_tb.sv

/* test/ddcpu_tb.sv */
`timescale 1ns/1ns

module ddcpu_tb;

   localparam int TD_WORDS  = 128;
   localparam int MAX_RES   = 16;
   localparam int RUN_LIMIT = 2000;

   logic        CLK;
   logic        RST;
   logic        i_start;
   logic [31:0] i_pcaddr;
   logic        o_stop;
   logic [31:0] o_araddr;
   logic        o_arvalid;
   logic        i_arready;
   logic [31:0] i_rdata;
   logic        i_rvalid;
   logic        o_rready;
   logic        o_res_valid;
   logic [11:0] o_res_tag;
   logic [15:0] o_res_value;
   logic        i_res_ready;

   logic [31:0] td [TD_WORDS];
   logic [31:0] mem [logic [31:0]];
   logic [11:0] exp_tag [MAX_RES];
   logic [15:0] exp_val [MAX_RES];
   bit          got [MAX_RES];
   int          exp_num;
   int          recv_count;
   int          error_count;
   int          check_count;
   bit          aborted;
   integer      seed;

   // AXI memory model state
   int          ar_wait;
   int          r_wait;
   bit          rd_busy;
   bit          end_fetched;
   logic [31:0] next_addr;
   logic [31:0] rd_word;

   // result held under back-pressure
   bit          held;
   logic [11:0] held_tag;
   logic [15:0] held_value;

   ddcpu_top #(.WORKER_NUM(3), .QUEUE_DEPTH(8)) uut (
      .CLK         (CLK),
      .RST         (RST),
      .i_start     (i_start),
      .i_pcaddr    (i_pcaddr),
      .o_stop      (o_stop),
      .o_araddr    (o_araddr),
      .o_arvalid   (o_arvalid),
      .i_arready   (i_arready),
      .i_rdata     (i_rdata),
      .i_rvalid    (i_rvalid),
      .o_rready    (o_rready),
      .o_res_valid (o_res_valid),
      .o_res_tag   (o_res_tag),
      .o_res_value (o_res_value),
      .i_res_ready (i_res_ready)
   );

   always #4 CLK = ~CLK;

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      end
   endtask

   task automatic report_error(input string msg);
      error_count++;
      $display("ERROR: %s", msg);
   endtask

   task automatic record_result(input logic [11:0] tag, input logic [15:0] value);
      int idx;
      idx = -1;
      if (o_stop) report_error($sformatf("result with tag 0x%h arrived after STOP", tag));
      for (int i = 0; i < exp_num; i++) begin
         if (exp_tag[i] == tag) idx = i;
      end
      if (idx < 0) begin
         report_error($sformatf("result with unexpected tag 0x%h", tag));
      end else if (got[idx]) begin
         report_error($sformatf("result with tag 0x%h received twice", tag));
      end else begin
         got[idx] = 1'b1;
         recv_count++;
         check_value("o_res_value", value, exp_val[idx]);
      end
   endtask

   // one run record: start, image, expected results
   task automatic load_run(inout int ptr, output logic [31:0] start);
      int n;
      start = td[ptr];
      n     = td[ptr + 1];
      ptr   = ptr + 2;
      mem.delete();
      for (int i = 0; i < n; i++) begin
         mem[td[ptr]] = td[ptr + 1];
         ptr = ptr + 2;
      end
      exp_num = td[ptr];
      ptr     = ptr + 1;
      for (int i = 0; i < exp_num; i++) begin
         exp_tag[i] = td[ptr][27:16];
         exp_val[i] = td[ptr][15:0];
         got[i]     = 1'b0;
         ptr        = ptr + 1;
      end
   endtask

   task automatic run_program(input logic [31:0] start);
      int n;
      recv_count  = 0;
      end_fetched = 1'b0;
      next_addr   = start;
      @(posedge CLK);
      #1;
      i_pcaddr = start;
      i_start  = 1'b1;
      @(posedge CLK);
      #1;
      i_start = 1'b0;
      @(posedge CLK);
      check_value("o_stop", o_stop, 32'd0);
      n = 0;
      while (!o_stop && n < RUN_LIMIT) begin
         @(posedge CLK);
         n++;
      end
      if (!o_stop) begin
         report_error("timed out waiting for o_stop to return high");
         aborted = 1'b1;
      end else begin
         if (!end_fetched) report_error("o_stop rose before the END word was fetched");
         check_value("result count", recv_count, exp_num);
         // late results get flagged by the monitor
         repeat (20) @(posedge CLK);
      end
   endtask

   // memory model, random ARREADY and RVALID delays
   always @(posedge CLK) begin
      if (RST) begin
         ar_wait = 0;
         r_wait  = 0;
         rd_busy = 1'b0;
      end else begin
         if (i_rvalid && o_rready) begin
            rd_busy = 1'b0;
            if (rd_word[31:28] == 4'h0) end_fetched = 1'b1;
            else if (rd_word[31:28] == 4'h1) next_addr = 32'(rd_word[27:0]) * 4;
            else next_addr = next_addr + 4;
         end
         if (o_arvalid && i_arready) begin
            if (end_fetched) report_error("read address issued after END");
            check_value("o_araddr", o_araddr, next_addr);
            if (mem.exists(o_araddr)) begin
               rd_word = mem[o_araddr];
            end else begin
               report_error($sformatf("read from unmapped address 0x%h", o_araddr));
               rd_word = o_araddr ^ 32'hDEAD_BEEF;
            end
            rd_busy = 1'b1;
            r_wait  = {$random(seed)} % 4;
            ar_wait = {$random(seed)} % 4;
         end else begin
            if (ar_wait > 0) ar_wait--;
            if (rd_busy && r_wait > 0) r_wait--;
         end
      end
      #1;
      i_arready   = (ar_wait == 0);
      i_rvalid    = rd_busy && (r_wait == 0);
      i_rdata     = rd_busy ? rd_word : 32'd0;
      i_res_ready = ({$random(seed)} % 4) != 0;
   end

   // result monitor
   always @(posedge CLK) begin
      if (RST) begin
         held = 1'b0;
      end else begin
         if (held) begin
            check_value("o_res_valid", o_res_valid, 32'd1);
            check_value("o_res_tag", o_res_tag, held_tag);
            check_value("o_res_value", o_res_value, held_value);
         end
         held       = o_res_valid && !i_res_ready;
         held_tag   = o_res_tag;
         held_value = o_res_value;
         if (o_res_valid && i_res_ready) record_result(o_res_tag, o_res_value);
      end
   end

   initial begin
      int          ptr;
      logic [31:0] start;
      CLK         = 1'b0;
      RST         = 1'b1;
      i_start     = 1'b0;
      i_pcaddr    = 32'd0;
      i_arready   = 1'b0;
      i_rdata     = 32'd0;
      i_rvalid    = 1'b0;
      i_res_ready = 1'b0;
      seed        = 89071;
      error_count = 0;
      check_count = 0;
      aborted     = 1'b0;
      exp_num     = 0;
      recv_count  = 0;
      end_fetched = 1'b0;
      next_addr   = 32'd0;
      rd_word     = 32'd0;
      $readmemh("test/ddcpu_testdata.txt", td);
      repeat (16) @(posedge CLK);
      #1;
      RST = 1'b0;
      @(posedge CLK);
      check_value("o_stop", o_stop, 32'd1);
      check_value("o_arvalid", o_arvalid, 32'd0);
      check_value("o_rready", o_rready, 32'd0);
      check_value("o_res_valid", o_res_valid, 32'd0);
      ptr = 0;
      for (int r = 0; r < 2; r++) begin
         load_run(ptr, start);
         if (!aborted) run_program(start);
      end
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

/* test/ddcpu_testdata.txt */
// per run: start address and entry count, then "byte_address word" entries,
// then result count and expected results as {4'h0, tag[11:0], value[15:0]}
00000100 00000008
00000100 20010005
00000104 50020003
00000108 30030001
0000010C 10000050
00000110 200F0000
00000140 40041234
00000144 50050101
00000148 00000000
00000005
00010006 00020009 0003FFFF 0004486E 00050201
00000200 0000000A
00000200 7010BEEF
00000204 501100FF
00000208 2012FFFF
0000020C 10000090
00000210 301F0001
00000240 30130010
00000244 50140123
00000248 4015FFFF
0000024C 20160010
00000250 00000000
00000007
0010BEEF 0011FE01 00120000 0013FFF0
00144AC9 0015A5A5 00160011
